/* logic/video_pkg.sv */
`default_nettype none

package video_pkg;

	typedef logic [2:0] rgb_t;

	// Bit 2 red, bit 1 green, bit 0 blue
	localparam rgb_t C_BLACK   = 3'b000;
	localparam rgb_t C_BLUE    = 3'b001;
	localparam rgb_t C_GREEN   = 3'b010;
	localparam rgb_t C_CYAN    = 3'b011;
	localparam rgb_t C_RED     = 3'b100;
	localparam rgb_t C_MAGENTA = 3'b101;
	localparam rgb_t C_YELLOW  = 3'b110;
	localparam rgb_t C_WHITE   = 3'b111;

	// Glyph size and cell pitch with one spacing column and row
	localparam int FONT_W      = 4;
	localparam int FONT_H      = 6;
	localparam int CELL_W      = FONT_W + 1;
	localparam int CELL_H      = FONT_H + 1;
	localparam int GLYPH_COUNT = 8;

endpackage

`default_nettype wire

/* logic/text_pkg.sv */
`default_nettype none

package text_pkg;

	typedef struct packed {
		logic       kind;
		logic       inverse;
		logic [5:0] code;
	} char_view_t;

	typedef struct packed {
		logic       kind;
		logic [3:0] unused;
		logic [2:0] color;
	} tile_view_t;

	// One cell word, read as a character or as a pin tile
	typedef union packed {
		char_view_t chr;
		tile_view_t tile;
	} text_cell_u;

	localparam logic CELL_KIND_TILE = 1'b1;

	localparam logic [9:0] ADDR_CTRL    = 10'h200;
	localparam logic [9:0] ADDR_PALETTE = 10'h204;

	// Field positions inside the control and palette words
	localparam int CTRL_SCALE_LSB   = 0;
	localparam int CTRL_SEL_ROW_LSB = 8;
	localparam int PAL_BG_LSB       = 0;
	localparam int PAL_TEXT_LSB     = 4;
	localparam int PAL_SEL_BG_LSB   = 8;
	localparam int PAL_SEL_TEXT_LSB = 12;

endpackage

`default_nettype wire

/* logic/font_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module font_rom (
	input  logic       clk,
	input  logic [5:0] addr,
	output logic [3:0] row
);

	localparam int DEPTH = video_pkg::GLYPH_COUNT * video_pkg::FONT_H;

	// Row r of glyph g sits at g*FONT_H + r, MSB is the leftmost pixel
	logic [3:0] mem [0:DEPTH-1];

	initial begin
		$readmemh("logic/font_rom.hex", mem);
	end

	always_ff @(posedge clk) begin
		if (32'(addr) < DEPTH)
			row <= mem[addr];
		else
			row <= 4'd0;
	end

endmodule

`default_nettype wire

/* logic/apb_text_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module apb_text_regs #(
	parameter int TEXT_COLS = 16,
	parameter int TEXT_ROWS = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [9:0]           paddr,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [31:0]          pwdata,
	output logic [31:0]          prdata,
	output logic                 pready,
	output logic                 pslverr,
	input  logic [6:0]           vid_addr,
	output text_pkg::text_cell_u vid_cell,
	output logic [2:0]           scale,
	output logic [2:0]           sel_row,
	output video_pkg::rgb_t      pal_bg,
	output video_pkg::rgb_t      pal_text,
	output video_pkg::rgb_t      pal_sel_bg,
	output video_pkg::rgb_t      pal_sel_text
);

	localparam int CELLS = TEXT_COLS * TEXT_ROWS;

	text_pkg::text_cell_u cell_ram [0:CELLS-1];
	text_pkg::text_cell_u ram_q;

	logic [6:0] cell_idx;
	logic hit_cell;
	logic hit_ctrl;
	logic hit_pal;
	logic access;
	logic wr_en;
	logic rd_wait;
	logic [31:0] ctrl_word;
	logic [31:0] pal_word;
	logic [2:0] scale_in;

	assign cell_idx = paddr[8:2];
	assign hit_cell = !paddr[9] && (paddr[1:0] == 2'b00) && (32'(cell_idx) < CELLS);
	assign hit_ctrl = paddr == text_pkg::ADDR_CTRL;
	assign hit_pal  = paddr == text_pkg::ADDR_PALETTE;

	assign access  = psel && penable;
	assign wr_en   = access && pwrite;
	// Writes finish at once, reads after one wait state
	assign pready  = access && (pwrite || rd_wait);
	assign pslverr = pready && !(hit_cell || hit_ctrl || hit_pal);

	// Scale outside 1 to 4 is clamped
	always_comb begin
		scale_in = pwdata[text_pkg::CTRL_SCALE_LSB +: 3];
		if (scale_in == 3'd0)
			scale_in = 3'd1;
		else if (scale_in > 3'd4)
			scale_in = 3'd4;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_wait      <= 1'b0;
			scale        <= 3'd1;
			sel_row      <= 3'd7;
			pal_bg       <= video_pkg::C_BLACK;
			pal_text     <= video_pkg::C_BLACK;
			pal_sel_bg   <= video_pkg::C_BLACK;
			pal_sel_text <= video_pkg::C_BLACK;
		end else begin
			rd_wait <= access && !pwrite && !rd_wait;
			if (wr_en && hit_ctrl) begin
				scale   <= scale_in;
				sel_row <= pwdata[text_pkg::CTRL_SEL_ROW_LSB +: 3];
			end
			if (wr_en && hit_pal) begin
				pal_bg       <= pwdata[text_pkg::PAL_BG_LSB +: 3];
				pal_text     <= pwdata[text_pkg::PAL_TEXT_LSB +: 3];
				pal_sel_bg   <= pwdata[text_pkg::PAL_SEL_BG_LSB +: 3];
				pal_sel_text <= pwdata[text_pkg::PAL_SEL_TEXT_LSB +: 3];
			end
		end
	end

	// Cell RAM, APB port plus registered video port
	always_ff @(posedge clk) begin
		if (wr_en && hit_cell)
			cell_ram[cell_idx] <= pwdata[7:0];
		ram_q    <= cell_ram[cell_idx];
		vid_cell <= cell_ram[vid_addr];
	end

	always_comb begin
		ctrl_word = '0;
		ctrl_word[text_pkg::CTRL_SCALE_LSB +: 3]   = scale;
		ctrl_word[text_pkg::CTRL_SEL_ROW_LSB +: 3] = sel_row;
		pal_word = '0;
		pal_word[text_pkg::PAL_BG_LSB +: 3]       = pal_bg;
		pal_word[text_pkg::PAL_TEXT_LSB +: 3]     = pal_text;
		pal_word[text_pkg::PAL_SEL_BG_LSB +: 3]   = pal_sel_bg;
		pal_word[text_pkg::PAL_SEL_TEXT_LSB +: 3] = pal_sel_text;
	end

	always_comb begin
		prdata = '0;
		if (rd_wait) begin
			if (hit_cell)
				prdata = {24'd0, ram_q};
			else if (hit_ctrl)
				prdata = ctrl_word;
			else if (hit_pal)
				prdata = pal_word;
		end
	end

endmodule

`default_nettype wire

/* logic/video_timing.sv */
`timescale 1ns/1ns
`default_nettype none

module video_timing #(
	parameter int H_ACTIVE  = 96,
	parameter int H_FRONT   = 4,
	parameter int H_SYNC    = 8,
	parameter int H_BACK    = 4,
	parameter int V_ACTIVE  = 48,
	parameter int V_FRONT   = 2,
	parameter int V_SYNC    = 2,
	parameter int V_BACK    = 2,
	parameter int TEXT_COLS = 16,
	parameter int TEXT_ROWS = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [2:0] scale,
	output logic       cell_start,
	output logic [6:0] cell_index,
	output logic [2:0] font_row,
	output logic [2:0] font_col,
	output logic       in_grid,
	output logic       hsync_la,
	output logic       vsync_la,
	output logic       de_la
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HW = $clog2(H_TOTAL);
	localparam int VW = $clog2(V_TOTAL);

	logic [HW-1:0] hcnt;
	logic [VW-1:0] vcnt;
	logic [HW-1:0] cx;
	logic [VW-1:0] cy;
	logic [2:0] sub_x;
	logic [2:0] sub_y;
	logic [2:0] fx;
	logic [2:0] fy;
	logic [2:0] sub_max;
	logic line_end;

	assign sub_max  = scale - 3'd1;
	assign line_end = hcnt == HW'(H_TOTAL - 1);

	// Horizontal position and scaled cell column
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hcnt  <= '0;
			sub_x <= '0;
			fx    <= '0;
			cx    <= '0;
		end else if (line_end) begin
			hcnt  <= '0;
			sub_x <= '0;
			fx    <= '0;
			cx    <= '0;
		end else begin
			hcnt <= hcnt + 1'b1;
			if (hcnt < HW'(H_ACTIVE)) begin
				if (sub_x >= sub_max) begin
					sub_x <= '0;
					if (fx == 3'(video_pkg::CELL_W - 1)) begin
						fx <= '0;
						cx <= cx + 1'b1;
					end else begin
						fx <= fx + 1'b1;
					end
				end else begin
					sub_x <= sub_x + 1'b1;
				end
			end
		end
	end

	// Vertical counters step once per line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vcnt  <= '0;
			sub_y <= '0;
			fy    <= '0;
			cy    <= '0;
		end else if (line_end) begin
			if (vcnt == VW'(V_TOTAL - 1)) begin
				vcnt  <= '0;
				sub_y <= '0;
				fy    <= '0;
				cy    <= '0;
			end else begin
				vcnt <= vcnt + 1'b1;
				if (vcnt < VW'(V_ACTIVE)) begin
					if (sub_y >= sub_max) begin
						sub_y <= '0;
						if (fy == 3'(video_pkg::CELL_H - 1)) begin
							fy <= '0;
							cy <= cy + 1'b1;
						end else begin
							fy <= fy + 1'b1;
						end
					end else begin
						sub_y <= sub_y + 1'b1;
					end
				end
			end
		end
	end

	assign de_la    = (hcnt < HW'(H_ACTIVE)) && (vcnt < VW'(V_ACTIVE));
	assign hsync_la = (hcnt >= HW'(H_ACTIVE + H_FRONT)) &&
		(hcnt < HW'(H_ACTIVE + H_FRONT + H_SYNC));
	assign vsync_la = (vcnt >= VW'(V_ACTIVE + V_FRONT)) &&
		(vcnt < VW'(V_ACTIVE + V_FRONT + V_SYNC));

	assign cell_start = de_la && (sub_x == '0) && (fx == '0);
	assign in_grid    = de_la && (cx < HW'(TEXT_COLS)) && (cy < VW'(TEXT_ROWS));
	assign cell_index = 7'(32'(cy) * TEXT_COLS + 32'(cx));
	assign font_col   = fx;
	assign font_row   = fy;

endmodule

`default_nettype wire

/* logic/fetch_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_sequencer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cell_start,
	input  logic [6:0]           cell_index,
	input  logic [2:0]           font_row,
	input  logic                 in_grid,
	input  text_pkg::text_cell_u vid_cell,
	output logic [6:0]           vid_addr,
	output logic [5:0]           rom_addr,
	input  logic [3:0]           rom_row,
	output logic [3:0]           glyph_row,
	output text_pkg::text_cell_u cell_out,
	output logic                 glyph_valid
);

	localparam logic [1:0] S_IDLE    = 2'd0;
	localparam logic [1:0] S_CELL    = 2'd1;
	localparam logic [1:0] S_GLYPH   = 2'd2;
	localparam logic [1:0] S_PRESENT = 2'd3;

	// Past the last glyph, the ROM answers with an empty row
	localparam logic [5:0] BLANK_ADDR = 6'd63;

	logic [1:0] state;
	logic [2:0] row_q;
	logic grid_q;
	text_pkg::text_cell_u cell_q;

	// Cell RAM read goes out in the cell_start cycle
	assign vid_addr = cell_index;

	always_comb begin
		rom_addr = BLANK_ADDR;
		if (state == S_CELL && vid_cell.chr.kind != text_pkg::CELL_KIND_TILE &&
				vid_cell.chr.code < 6'(video_pkg::GLYPH_COUNT)) begin
			rom_addr = 6'(vid_cell.chr.code * video_pkg::FONT_H + row_q);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= S_IDLE;
			grid_q      <= 1'b0;
			glyph_valid <= 1'b0;
		end else begin
			case (state)
				S_IDLE, S_PRESENT: begin
					if (cell_start) begin
						state  <= S_CELL;
						grid_q <= in_grid;
					end else begin
						state <= S_IDLE;
					end
				end
				S_CELL:  state <= S_GLYPH;
				S_GLYPH: begin
					state       <= S_PRESENT;
					glyph_valid <= grid_q;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cell_start)
			row_q <= font_row;
		if (state == S_CELL)
			cell_q <= vid_cell;
		// Cells off the grid go out blank
		if (state == S_GLYPH) begin
			glyph_row <= grid_q ? rom_row : 4'd0;
			cell_out  <= grid_q ? cell_q : '0;
		end
	end

endmodule

`default_nettype wire

/* logic/pixel_shader.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_shader (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [3:0]           glyph_row,
	input  text_pkg::text_cell_u cell_out,
	input  logic                 glyph_valid,
	input  logic [2:0]           font_col,
	input  logic [2:0]           font_row,
	input  logic                 in_grid,
	input  logic                 hsync_la,
	input  logic                 vsync_la,
	input  logic                 de_la,
	input  logic [2:0]           sel_row,
	input  video_pkg::rgb_t      pal_bg,
	input  video_pkg::rgb_t      pal_text,
	input  video_pkg::rgb_t      pal_sel_bg,
	input  video_pkg::rgb_t      pal_sel_text,
	output video_pkg::rgb_t      rgb,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 de
);

	// Glyph data trails the lookahead flags by this many cycles
	localparam int LAT = 3;
	localparam logic [1:0] COL_MSB = 2'(video_pkg::FONT_W - 1);

	logic [4:0] row_cnt;
	logic [4:0] row_now;
	logic [2:0] prev_fy;
	logic sel_hit;
	logic [10:0] flags;
	logic [10:0] pipe [0:LAT-1];
	logic de_d;
	logic hs_d;
	logic vs_d;
	logic grid_d;
	logic sel_d;
	logic [2:0] col_d;
	logic [2:0] row_d;
	logic glyph_bit;
	video_pkg::rgb_t bg;
	video_pkg::rgb_t fg;
	video_pkg::rgb_t pix;

	// Text row tracked from font row wrap
	assign row_now = (de_la && font_row != prev_fy && font_row == 3'd0) ?
		row_cnt + 5'd1 : row_cnt;
	assign sel_hit = row_now == {2'b00, sel_row};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_cnt <= '0;
			prev_fy <= '0;
		end else if (vsync_la) begin
			row_cnt <= '0;
			prev_fy <= '0;
		end else begin
			row_cnt <= row_now;
			if (de_la)
				prev_fy <= font_row;
		end
	end

	assign flags = {de_la, hsync_la, vsync_la, in_grid, sel_hit, font_col, font_row};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < LAT; i++)
				pipe[i] <= '0;
		end else begin
			pipe[0] <= flags;
			for (int i = 1; i < LAT; i++)
				pipe[i] <= pipe[i-1];
		end
	end

	assign {de_d, hs_d, vs_d, grid_d, sel_d, col_d, row_d} = pipe[LAT-1];

	assign bg = sel_d ? pal_sel_bg : pal_bg;
	assign fg = sel_d ? pal_sel_text : pal_text;
	assign glyph_bit = glyph_row[COL_MSB - col_d[1:0]] ^ cell_out.chr.inverse;

	always_comb begin
		if (!de_d)
			pix = video_pkg::C_BLACK;
		else if (!grid_d || !glyph_valid)
			pix = bg;
		else if (col_d == 3'(video_pkg::FONT_W) || row_d == 3'(video_pkg::FONT_H))
			pix = bg;
		else if (cell_out.tile.kind == text_pkg::CELL_KIND_TILE)
			pix = cell_out.tile.color;
		else
			pix = glyph_bit ? fg : bg;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rgb   <= video_pkg::C_BLACK;
			de    <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			rgb   <= pix;
			de    <= de_d;
			hsync <= hs_d;
			vsync <= vs_d;
		end
	end

endmodule

`default_nettype wire

/* logic/text_renderer.sv */
`timescale 1ns/1ns
`default_nettype none

module text_renderer #(
	parameter int H_ACTIVE  = 96,
	parameter int H_FRONT   = 4,
	parameter int H_SYNC    = 8,
	parameter int H_BACK    = 4,
	parameter int V_ACTIVE  = 48,
	parameter int V_FRONT   = 2,
	parameter int V_SYNC    = 2,
	parameter int V_BACK    = 2,
	parameter int TEXT_COLS = 16,
	parameter int TEXT_ROWS = 8
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [9:0]          paddr,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,
	output video_pkg::rgb_t     rgb,
	output logic                hsync,
	output logic                vsync,
	output logic                de
);

	logic [6:0] vid_addr;
	text_pkg::text_cell_u vid_cell;
	logic [2:0] scale;
	logic [2:0] sel_row;
	video_pkg::rgb_t pal_bg;
	video_pkg::rgb_t pal_text;
	video_pkg::rgb_t pal_sel_bg;
	video_pkg::rgb_t pal_sel_text;

	logic cell_start;
	logic [6:0] cell_index;
	logic [2:0] font_row;
	logic [2:0] font_col;
	logic in_grid;
	logic hsync_la;
	logic vsync_la;
	logic de_la;

	logic [5:0] rom_addr;
	logic [3:0] rom_row;
	logic [3:0] glyph_row;
	text_pkg::text_cell_u cell_out;
	logic glyph_valid;

	apb_text_regs #(
		.TEXT_COLS (TEXT_COLS),
		.TEXT_ROWS (TEXT_ROWS)
	) u_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.vid_addr     (vid_addr),
		.vid_cell     (vid_cell),
		.scale        (scale),
		.sel_row      (sel_row),
		.pal_bg       (pal_bg),
		.pal_text     (pal_text),
		.pal_sel_bg   (pal_sel_bg),
		.pal_sel_text (pal_sel_text)
	);

	video_timing #(
		.H_ACTIVE  (H_ACTIVE),
		.H_FRONT   (H_FRONT),
		.H_SYNC    (H_SYNC),
		.H_BACK    (H_BACK),
		.V_ACTIVE  (V_ACTIVE),
		.V_FRONT   (V_FRONT),
		.V_SYNC    (V_SYNC),
		.V_BACK    (V_BACK),
		.TEXT_COLS (TEXT_COLS),
		.TEXT_ROWS (TEXT_ROWS)
	) u_timing (
		.clk        (clk),
		.rst_n      (rst_n),
		.scale      (scale),
		.cell_start (cell_start),
		.cell_index (cell_index),
		.font_row   (font_row),
		.font_col   (font_col),
		.in_grid    (in_grid),
		.hsync_la   (hsync_la),
		.vsync_la   (vsync_la),
		.de_la      (de_la)
	);

	fetch_sequencer u_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.cell_start  (cell_start),
		.cell_index  (cell_index),
		.font_row    (font_row),
		.in_grid     (in_grid),
		.vid_cell    (vid_cell),
		.vid_addr    (vid_addr),
		.rom_addr    (rom_addr),
		.rom_row     (rom_row),
		.glyph_row   (glyph_row),
		.cell_out    (cell_out),
		.glyph_valid (glyph_valid)
	);

	font_rom u_font (
		.clk  (clk),
		.addr (rom_addr),
		.row  (rom_row)
	);

	pixel_shader u_shader (
		.clk          (clk),
		.rst_n        (rst_n),
		.glyph_row    (glyph_row),
		.cell_out     (cell_out),
		.glyph_valid  (glyph_valid),
		.font_col     (font_col),
		.font_row     (font_row),
		.in_grid      (in_grid),
		.hsync_la     (hsync_la),
		.vsync_la     (vsync_la),
		.de_la        (de_la),
		.sel_row      (sel_row),
		.pal_bg       (pal_bg),
		.pal_text     (pal_text),
		.pal_sel_bg   (pal_sel_bg),
		.pal_sel_text (pal_sel_text),
		.rgb          (rgb),
		.hsync        (hsync),
		.vsync        (vsync),
		.de           (de)
	);

endmodule

`default_nettype wire

/* tests/renderer_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module renderer_asserts (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic pready,
	input logic pslverr,
	input logic de,
	input logic hsync,
	input logic vsync
);

	int fails;

	de_outside_sync: assert property (@(posedge clk) disable iff (!rst_n)
		!(de && (hsync || vsync)))
		else begin
			fails++;
			$error("de is high while hsync or vsync is high");
		end

	err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr |-> pready)
		else begin
			fails++;
			$error("pslverr is high without pready");
		end

	// First access cycle of a read is always a wait state
	read_wait_state: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && penable && !pwrite && !$past(penable)) |-> !pready)
		else begin
			fails++;
			$error("read completed in its first access cycle");
		end

endmodule

bind text_renderer renderer_asserts u_asserts (
	.clk     (clk),
	.rst_n   (rst_n),
	.psel    (psel),
	.penable (penable),
	.pwrite  (pwrite),
	.pready  (pready),
	.pslverr (pslverr),
	.de      (de),
	.hsync   (hsync),
	.vsync   (vsync)
);

`default_nettype wire

/* tests/pixel_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_checker #(
	parameter int H_ACTIVE = 96,
	parameter int H_SYNC   = 8,
	parameter int V_ACTIVE = 48
) (
	input logic            clk,
	input logic            rst_n,
	input logic [9:0]      paddr,
	input logic            psel,
	input logic            penable,
	input logic [31:0]     prdata,
	input logic            pready,
	input logic            pslverr,
	input video_pkg::rgb_t rgb,
	input logic            hsync,
	input logic            vsync,
	input logic            de
);

	localparam int PIXELS = H_ACTIVE * V_ACTIVE;

	int errors;
	bit exp_valid [0:PIXELS-1];
	video_pkg::rgb_t exp_col [0:PIXELS-1];
	int pix_cnt;
	bit armed;
	bit active;
	logic vsync_q;
	logic hsync_q;
	logic de_q;
	int hs_run;
	bit hs_seen;
	bit de_seen;
	int line_px;
	logic acc_read [$];
	logic [31:0] acc_data [$];
	logic acc_err [$];
	event frame_done;

	task automatic want_pixel(input int x, input int y, input int colour);
		if (x >= H_ACTIVE || y >= V_ACTIVE) begin
			errors++;
			$display("pixel %0d,%0d lies outside the active area", x, y);
		end else begin
			exp_valid[y * H_ACTIVE + x] = 1'b1;
			exp_col[y * H_ACTIVE + x] = 3'(colour);
		end
	endtask

	task automatic fill_expected(input int colour);
		for (int i = 0; i < PIXELS; i++) begin
			exp_valid[i] = 1'b1;
			exp_col[i] = 3'(colour);
		end
	endtask

	task automatic arm_frame();
		armed = 1'b1;
	endtask

	task automatic wait_frame();
		@(frame_done);
	endtask

	task automatic queue_access(input logic is_read, input logic [31:0] data, input logic err);
		acc_read.push_back(is_read);
		acc_data.push_back(data);
		acc_err.push_back(err);
	endtask

	// Sampled mid-cycle, away from the rising edge
	always @(negedge clk) begin
		logic rd;
		logic [31:0] want_data;
		logic want_err;
		if (!rst_n) begin
			pix_cnt = 0;
			vsync_q = 1'b0;
			hsync_q = 1'b0;
			de_q = 1'b0;
			hs_run = 0;
			hs_seen = 1'b0;
			de_seen = 1'b0;
			line_px = 0;
			if (armed) begin
				active = 1'b1;
				armed = 1'b0;
			end
			if (de || hsync || vsync || pready || pslverr || rgb != 3'd0) begin
				errors++;
				$display("error @%0t: outputs not at their reset values", $time);
			end
		end else begin
			if (vsync_q && !vsync) begin
				pix_cnt = 0;
				if (armed) begin
					active = 1'b1;
					armed = 1'b0;
				end
			end
			vsync_q = vsync;
			// Sync pulse width and one pulse between active lines
			if (hsync) begin
				hs_run++;
			end else if (hsync_q) begin
				if (hs_run != H_SYNC) begin
					errors++;
					$display("error @%0t: hsync pulse of %0d cycles, expected %0d", $time,
						hs_run, H_SYNC);
				end
				hs_run = 0;
				hs_seen = 1'b1;
			end
			hsync_q = hsync;
			if (de && !de_q) begin
				if (de_seen && !hs_seen) begin
					errors++;
					$display("no hsync pulse between two active lines");
				end
				hs_seen = 1'b0;
				de_seen = 1'b1;
				line_px = 0;
			end
			if (de)
				line_px++;
			if (!de && de_q && line_px != H_ACTIVE) begin
				errors++;
				$display("error @%0t: line of %0d de pixels, expected %0d", $time,
					line_px, H_ACTIVE);
			end
			de_q = de;
			if (!de && rgb !== 3'd0) begin
				errors++;
				$display("error @%0t: rgb %0d outside de", $time, rgb);
			end
			if (de) begin
				if (active && exp_valid[pix_cnt] && rgb !== exp_col[pix_cnt]) begin
					errors++;
					$display("error @%0t: pixel (%0d,%0d) shows %0d, expected %0d", $time,
						pix_cnt % H_ACTIVE, pix_cnt / H_ACTIVE, rgb, exp_col[pix_cnt]);
				end
				pix_cnt++;
				if (active && pix_cnt == PIXELS) begin
					active = 1'b0;
					for (int i = 0; i < PIXELS; i++)
						exp_valid[i] = 1'b0;
					-> frame_done;
				end
			end
			if (psel && penable && pready) begin
				if (acc_read.size() == 0) begin
					errors++;
					$display("an APB transfer completed with no expectation queued");
				end else begin
					rd = acc_read.pop_front();
					want_data = acc_data.pop_front();
					want_err = acc_err.pop_front();
					if (pslverr !== want_err) begin
						errors++;
						$display("error @%0t: addr %03h pslverr %0b, expected %0b", $time,
							paddr, pslverr, want_err);
					end
					if (rd && prdata !== want_data) begin
						errors++;
						$display("error @%0t: addr %03h read %08h, expected %08h", $time,
							paddr, prdata, want_data);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* tests/tb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_top;

	localparam int H_ACTIVE = 96;
	localparam int H_FRONT  = 4;
	localparam int H_SYNC   = 8;
	localparam int H_BACK   = 4;
	localparam int V_ACTIVE = 48;
	localparam int V_FRONT  = 2;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 2;
	localparam longint FRAME_NS = longint'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK) *
		(V_ACTIVE + V_FRONT + V_SYNC + V_BACK) * 20;

	logic clk;
	logic rst_n;
	logic [9:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	video_pkg::rgb_t rgb;
	logic hsync;
	logic vsync;
	logic de;

	byte kinds [$];
	logic [31:0] arg_a [$];
	logic [31:0] arg_b [$];
	logic [31:0] arg_c [$];
	int p_lines;
	bit loaded;
	bit pending;
	longint limit_ns;

	text_renderer #(
		.H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
		.V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
		.TEXT_COLS (16), .TEXT_ROWS (8)
	) dut0 (
		.clk (clk), .rst_n (rst_n), .paddr (paddr), .psel (psel), .penable (penable),
		.pwrite (pwrite), .pwdata (pwdata), .prdata (prdata), .pready (pready),
		.pslverr (pslverr), .rgb (rgb), .hsync (hsync), .vsync (vsync), .de (de)
	);

	pixel_checker #(.H_ACTIVE (H_ACTIVE), .H_SYNC (H_SYNC), .V_ACTIVE (V_ACTIVE)) chk (
		.clk (clk), .rst_n (rst_n), .paddr (paddr), .psel (psel), .penable (penable),
		.prdata (prdata), .pready (pready), .pslverr (pslverr), .rgb (rgb),
		.hsync (hsync), .vsync (vsync), .de (de)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic load_testdata(output bit ok);
		int fd;
		int n;
		string line;
		byte kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		ok = 1'b1;
		fd = $fopen("tests/renderer_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/renderer_testdata.txt");
			ok = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != "/") begin
					if ($sscanf(line, "%c %h %h %h", kind, a, b, c) == 4 &&
							(kind == "W" || kind == "R" || kind == "P")) begin
						kinds.push_back(kind);
						arg_a.push_back(a);
						arg_b.push_back(b);
						arg_c.push_back(c);
						if (kind == "P")
							p_lines++;
					end else begin
						$display("malformed testdata line: %s", line);
						ok = 1'b0;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Zero wait states on writes, one on reads
	task automatic apb_transfer(input logic write, input logic [9:0] addr,
			input logic [31:0] data);
		@(posedge clk);
		#2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#2;
		penable = 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		@(posedge clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_pending_frame();
		if (pending) begin
			chk.arm_frame();
			chk.wait_frame();
			pending = 1'b0;
		end
	endtask

	task automatic run_records();
		for (int i = 0; i < kinds.size(); i++) begin
			if (kinds[i] == "P") begin
				chk.want_pixel(arg_a[i], arg_b[i], arg_c[i]);
				pending = 1'b1;
			end else begin
				check_pending_frame();
				repeat ($urandom_range(3, 0)) @(posedge clk);
				chk.queue_access(kinds[i] == "R", kinds[i] == "R" ? arg_b[i] : 32'd0,
					arg_c[i][0]);
				apb_transfer(kinds[i] == "W", arg_a[i][9:0], arg_b[i]);
			end
		end
		check_pending_frame();
	endtask

	initial begin
		bit ok;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		void'($urandom(15180));
		load_testdata(ok);
		if (!ok) begin
			$display("sim failed");
			$finish;
		end else begin
			limit_ns = longint'(p_lines + 2) * FRAME_NS + 10_000;
			loaded = 1'b1;
			// Palette is black after reset, so the whole first frame is too
			chk.fill_expected(0);
			chk.arm_frame();
			repeat (2) @(posedge clk);
			#2;
			rst_n = 1'b1;
			chk.wait_frame();
			run_records();
			$display("errors: %0d from checks, %0d from assertions", chk.errors,
				dut0.u_asserts.fails);
			if (chk.errors + dut0.u_asserts.fails == 0)
				$display("sim passed");
			else
				$display("sim failed");
			$finish;
		end
	end

	initial begin
		wait (loaded);
		#(limit_ns);
		$display("run timed out after %0d ns", limit_ns);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/font_rom.hex */
6
9
9
9
9
6
2
6
2
2
2
7
E
1
6
8
8
F
E
1
6
1
1
E
9
9
6
6
9
9
6
9
2
4
0
4
E
9
9
E
8
8
A
5
A
5
A
5

/* tests/renderer_testdata.txt */
// W addr data pslverr | R addr expected_data pslverr
// P x y expected_rgb, checked over the next full frame (all fields hex)
R 200 00000701 0
R 204 00000000 0
W 204 00006471 0
W 200 00000101 0
W 000 00000001 0
W 004 00000082 0
W 008 00000044 0
W 040 00000000 0
R 004 00000082 0
R 008 00000044 0
R 200 00000101 0
W 300 00000005 1
R 300 00000000 1
R 204 00006471 0
P 002 000 7
P 000 000 1
P 004 001 1
P 002 006 1
P 001 005 7
P 005 000 2
P 008 005 2
P 009 000 1
P 00a 000 1
P 00b 000 7
P 001 007 6
P 000 007 4
P 055 007 4
P 05a 003 1
W 200 00000102 0
P 004 000 7
P 008 000 1
P 00a 000 2
P 016 000 7
P 002 00e 6
P 000 00f 4

/* flist.f */
logic/video_pkg.sv
logic/text_pkg.sv
logic/font_rom.sv
logic/apb_text_regs.sv
logic/video_timing.sv
logic/fetch_sequencer.sv
logic/pixel_shader.sv
logic/text_renderer.sv
tests/renderer_asserts.sv
tests/pixel_checker.sv
tests/tb_top.sv
